// ==== hw/hawkeye_macros.svh ====
`ifndef HAWKEYE_MACROS_SVH
`define HAWKEYE_MACROS_SVH

// Stream word widths.
`define HAWKEYE_DIN_WIDTH  32
`define HAWKEYE_DOUT_WIDTH 32

// Entries per stream FIFO.
`define HAWKEYE_FIFO_DEPTH 8

`define HAWKEYE_UART_DIV 16 // Clock cycles per UART bit.

// Host bus address and register map.
`define HAWKEYE_ADDR_WIDTH 4
`define HAWKEYE_REG_DATA   4'h0
`define HAWKEYE_REG_STATUS 4'h4
`define HAWKEYE_REG_UART   4'h8
`define HAWKEYE_REG_CTRL   4'hC

`endif

// ==== hw/hawkeye_pkg.sv ====
`default_nettype none

`include "hawkeye_macros.svh"

package hawkeye_pkg;

    // Stream words.
    typedef logic [`HAWKEYE_DIN_WIDTH-1:0]  din_t;
    typedef logic [`HAWKEYE_DOUT_WIDTH-1:0] dout_t;

    // Host bus request that is accepted on req_i && gnt_o.
    typedef struct packed {
        logic [`HAWKEYE_ADDR_WIDTH-1:0] addr;
        logic                           we;
        logic [3:0]                     be;
        logic [31:0]                    wdata;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } bus_rsp_t;

    typedef enum logic [`HAWKEYE_ADDR_WIDTH-1:0] {
        REG_DATA   = `HAWKEYE_REG_DATA,
        REG_STATUS = `HAWKEYE_REG_STATUS,
        REG_UART   = `HAWKEYE_REG_UART,
        REG_CTRL   = `HAWKEYE_REG_CTRL
    } reg_addr_e;

    // STATUS register layout with rx_level in the low byte.
    typedef struct packed {
        logic [12:0] reserved;
        logic        uart_busy;
        logic        tx_full;
        logic        rx_empty;
        logic [7:0]  tx_level;
        logic [7:0]  rx_level;
    } status_t;

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

endpackage

`default_nettype wire

// ==== hw/hawkeye_stream_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module hawkeye_stream_fifo #(
    parameter int Width = 32,
    parameter int Depth = 8
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             flush_i,

    input  logic [Width-1:0] in_data_i,
    input  logic             in_valid_i,
    output logic             in_ready_o,

    output logic [Width-1:0] out_data_o,
    output logic             out_valid_o,
    input  logic             out_ready_i,

    output logic [7:0]       level_o
);

    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW = $clog2(Depth + 1);

    logic [Width-1:0] mem_q [Depth];
    logic [PtrW-1:0]  wr_ptr_q;
    logic [PtrW-1:0]  rd_ptr_q;
    logic [CntW-1:0]  count_q;
    logic             push;
    logic             pop;

    // Pointers wrap at Depth, which need not be a power of two.
    function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
        if (ptr == PtrW'(Depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign in_ready_o  = (count_q != CntW'(Depth));
    assign out_valid_o = (count_q != '0);
    assign out_data_o  = mem_q[rd_ptr_q]; // Head shown without a pop.
    assign level_o     = 8'(count_q);

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
            if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/hawkeye_uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hawkeye_macros.svh"

module hawkeye_uart_tx (
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  logic       start_i,
    input  logic [7:0] byte_i,
    output logic       busy_o,

    output logic       tx_o
);

    localparam int Div    = `HAWKEYE_UART_DIV;
    localparam int TimerW = (Div > 1) ? $clog2(Div) : 1;

    hawkeye_pkg::uart_state_e state_q;

    logic [TimerW-1:0] timer_q;
    logic [2:0]        idx_q;
    logic [7:0]        shift_q;
    logic              tx_q;
    logic              bit_done;

    assign bit_done = (timer_q == TimerW'(Div - 1)); // Last cycle of a bit.
    assign busy_o   = (state_q != hawkeye_pkg::UART_IDLE);
    assign tx_o     = tx_q;

    // The line is registered so that it never glitches between bits.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= hawkeye_pkg::UART_IDLE;
            timer_q <= '0;
            idx_q   <= '0;
            tx_q    <= 1'b1;
        end else begin
            case (state_q)
                hawkeye_pkg::UART_IDLE: begin
                    if (start_i) begin
                        state_q <= hawkeye_pkg::UART_START;
                        timer_q <= '0;
                        tx_q    <= 1'b0; // Start bit.
                    end
                end
                hawkeye_pkg::UART_START: begin
                    if (bit_done) begin
                        state_q <= hawkeye_pkg::UART_DATA;
                        timer_q <= '0;
                        idx_q   <= '0;
                        tx_q    <= shift_q[0];
                    end else begin
                        timer_q <= timer_q + 1'b1;
                    end
                end
                hawkeye_pkg::UART_DATA: begin
                    if (bit_done) begin
                        timer_q <= '0;
                        idx_q   <= idx_q + 1'b1;
                        if (idx_q == 3'd7) begin
                            state_q <= hawkeye_pkg::UART_STOP;
                            tx_q    <= 1'b1; // Stop bit.
                        end else begin
                            tx_q <= shift_q[1];
                        end
                    end else begin
                        timer_q <= timer_q + 1'b1;
                    end
                end
                default: begin
                    if (bit_done) begin
                        state_q <= hawkeye_pkg::UART_IDLE;
                        timer_q <= '0;
                    end else begin
                        timer_q <= timer_q + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB first.
    always_ff @(posedge clk_i) begin
        if (state_q == hawkeye_pkg::UART_IDLE && start_i) begin
            shift_q <= byte_i;
        end else if (state_q == hawkeye_pkg::UART_DATA && bit_done) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

endmodule

`default_nettype wire

// ==== hw/hawkeye_periph.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hawkeye_macros.svh"

module hawkeye_periph (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Host bus.
    input  logic                  req_i,
    output logic                  gnt_o,
    input  hawkeye_pkg::bus_req_t req_data_i,
    output logic                  rvalid_o,
    input  logic                  rready_i,
    output hawkeye_pkg::bus_rsp_t rsp_o,

    // DIN
    input  hawkeye_pkg::din_t     din_i,
    input  logic                  din_valid_i,
    output logic                  din_ready_o,

    // DOUT
    output hawkeye_pkg::dout_t    dout_o,
    output logic                  dout_valid_o,
    input  logic                  dout_ready_i,

    // UART transmitter.
    output logic                  uart_start_o,
    output logic [7:0]            uart_byte_o,
    input  logic                  uart_busy_i
);

    hawkeye_pkg::reg_addr_e addr_e;
    hawkeye_pkg::din_t      rx_data;
    hawkeye_pkg::dout_t     tx_data;
    hawkeye_pkg::status_t   status;
    hawkeye_pkg::bus_rsp_t  rsp_q;

    logic        accept;
    logic        stall;
    logic        is_rd;
    logic        is_wr;
    logic        rx_valid;
    logic        rx_pop;
    logic        tx_push;
    logic        tx_ready;
    logic        flush;
    logic [7:0]  rx_level;
    logic [7:0]  tx_level;
    logic [31:0] rdata_d;
    logic        rvalid_q;

    assign addr_e = hawkeye_pkg::reg_addr_e'(req_data_i.addr);
    assign is_wr  = req_data_i.we;
    assign is_rd  = !req_data_i.we;

    // A full TX FIFO or a busy transmitter holds off only the write that needs it.
    assign stall = (is_wr && addr_e == hawkeye_pkg::REG_DATA && !tx_ready)
                || (is_wr && addr_e == hawkeye_pkg::REG_UART && uart_busy_i);

    assign gnt_o  = !rvalid_q && !(req_i && stall);
    assign accept = req_i && gnt_o;

    assign rx_pop  = accept && is_rd && addr_e == hawkeye_pkg::REG_DATA && rx_valid;
    assign tx_push = accept && is_wr && addr_e == hawkeye_pkg::REG_DATA;
    assign tx_data = hawkeye_pkg::dout_t'(req_data_i.wdata);
    assign flush   = accept && is_wr && addr_e == hawkeye_pkg::REG_CTRL
                  && req_data_i.wdata[0];

    assign uart_start_o = accept && is_wr && addr_e == hawkeye_pkg::REG_UART
                       && req_data_i.be[0];
    assign uart_byte_o  = req_data_i.wdata[7:0];

    always_comb begin
        status           = '0;
        status.rx_level  = rx_level;
        status.tx_level  = tx_level;
        status.rx_empty  = !rx_valid;
        status.tx_full   = !tx_ready;
        status.uart_busy = uart_busy_i;
    end

    // Writes and the UART/CTRL reads answer zero.
    always_comb begin
        rdata_d = '0;
        if (is_rd) begin
            case (addr_e)
                hawkeye_pkg::REG_DATA:   if (rx_valid) rdata_d = 32'(rx_data);
                hawkeye_pkg::REG_STATUS: rdata_d = status;
                default:                 rdata_d = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
        end else if (accept) begin
            rvalid_q <= 1'b1;
        end else if (rready_i) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) rsp_q.rdata <= rdata_d; // Held until taken.
    end

    assign rvalid_o = rvalid_q;
    assign rsp_o    = rsp_q;

    hawkeye_stream_fifo #(
        .Width ($bits(hawkeye_pkg::din_t)),
        .Depth (`HAWKEYE_FIFO_DEPTH)
    ) i_rx_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush),
        .in_data_i   (din_i),
        .in_valid_i  (din_valid_i),
        .in_ready_o  (din_ready_o),
        .out_data_o  (rx_data),
        .out_valid_o (rx_valid),
        .out_ready_i (rx_pop),
        .level_o     (rx_level)
    );

    hawkeye_stream_fifo #(
        .Width ($bits(hawkeye_pkg::dout_t)),
        .Depth (`HAWKEYE_FIFO_DEPTH)
    ) i_tx_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush),
        .in_data_i   (tx_data),
        .in_valid_i  (tx_push),
        .in_ready_o  (tx_ready),
        .out_data_o  (dout_o),
        .out_valid_o (dout_valid_o),
        .out_ready_i (dout_ready_i),
        .level_o     (tx_level)
    );

endmodule

`default_nettype wire

// ==== hw/hawkeye_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hawkeye_top (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    output logic                  uart_tx_o,

    // Host bus.
    input  logic                  req_i,
    output logic                  gnt_o,
    input  hawkeye_pkg::bus_req_t req_data_i,
    output logic                  rvalid_o,
    input  logic                  rready_i,
    output hawkeye_pkg::bus_rsp_t rsp_o,

    // DIN
    input  hawkeye_pkg::din_t     din_i,
    input  logic                  din_valid_i,
    output logic                  din_ready_o,

    // DOUT
    output hawkeye_pkg::dout_t    dout_o,
    output logic                  dout_valid_o,
    input  logic                  dout_ready_i
);

    logic       uart_start;
    logic [7:0] uart_byte;
    logic       uart_busy;

    hawkeye_periph i_periph (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),

        .req_i      (req_i),
        .gnt_o      (gnt_o),
        .req_data_i (req_data_i),
        .rvalid_o   (rvalid_o),
        .rready_i   (rready_i),
        .rsp_o      (rsp_o),

        .din_i       (din_i),
        .din_valid_i (din_valid_i),
        .din_ready_o (din_ready_o),

        .dout_o       (dout_o),
        .dout_valid_o (dout_valid_o),
        .dout_ready_i (dout_ready_i),

        .uart_start_o (uart_start),
        .uart_byte_o  (uart_byte),
        .uart_busy_i  (uart_busy)
    );

    hawkeye_uart_tx i_uart_tx (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .start_i (uart_start),
        .byte_i  (uart_byte),
        .busy_o  (uart_busy),
        .tx_o    (uart_tx_o)
    );

endmodule

`default_nettype wire

// ==== verification/hawkeye_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hawkeye_macros.svh"

module hawkeye_chk (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  req_i,
    input  logic                  gnt_o,
    input  hawkeye_pkg::bus_req_t req_data_i,
    input  logic                  rvalid_o,
    input  logic                  rready_i,
    input  hawkeye_pkg::bus_rsp_t rsp_o,
    input  hawkeye_pkg::dout_t    dout_o,
    input  logic                  dout_valid_o,
    input  logic                  dout_ready_i,
    input  logic                  uart_tx_o
);

    logic accept;
    logic flush;
    logic uart_written_q;
    int   fail_count = 0;

    assign accept = req_i && gnt_o;
    assign flush  = accept && req_data_i.we && req_data_i.addr == `HAWKEYE_REG_CTRL
                 && req_data_i.wdata[0]; // A flush may drop dout_valid_o under back-pressure.

    // Set by the first UART write that sends a byte.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            uart_written_q <= 1'b0;
        end else if (accept && req_data_i.we && req_data_i.addr == `HAWKEYE_REG_UART
                     && req_data_i.be[0]) begin
            uart_written_q <= 1'b1;
        end
    end

    a_rsp_after_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        accept |=> rvalid_o)
        else begin
            $error("rvalid_o missing after acceptance");
            fail_count++;
        end

    a_rsp_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(rvalid_o) |-> $past(accept))
        else begin
            $error("rvalid_o rose without an accepted request");
            fail_count++;
        end

    a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rsp_o))
        else begin
            $error("response changed before it was taken");
            fail_count++;
        end

    a_no_gnt_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rvalid_o |-> !gnt_o)
        else begin
            $error("grant while a response is pending");
            fail_count++;
        end

    a_dout_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dout_valid_o && !dout_ready_i && !flush |=> dout_valid_o && $stable(dout_o))
        else begin
            $error("dout changed under back-pressure");
            fail_count++;
        end

    a_uart_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !uart_written_q |-> uart_tx_o)
        else begin
            $error("uart_tx_o left idle before any UART write");
            fail_count++;
        end

endmodule

bind hawkeye_top hawkeye_chk i_chk (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (req_i),
    .gnt_o        (gnt_o),
    .req_data_i   (req_data_i),
    .rvalid_o     (rvalid_o),
    .rready_i     (rready_i),
    .rsp_o        (rsp_o),
    .dout_o       (dout_o),
    .dout_valid_o (dout_valid_o),
    .dout_ready_i (dout_ready_i),
    .uart_tx_o    (uart_tx_o)
);

`default_nettype wire

// ==== verification/hawkeye_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hawkeye_macros.svh"

module hawkeye_tb;

    localparam int Depth    = `HAWKEYE_FIFO_DEPTH;
    localparam int Div      = `HAWKEYE_UART_DIV;
    localparam int WdCycles = 40 * 10 * Div + 4000; // 40 UART frames plus the stream tests.

    logic clk;
    logic rst_n;
    logic req;
    logic gnt;
    logic rvalid;
    logic rready;
    logic din_valid;
    logic din_ready;
    logic dout_valid;
    logic dout_ready;
    logic uart_tx;
    logic dout_rand_en;

    hawkeye_pkg::bus_req_t req_data;
    hawkeye_pkg::bus_rsp_t rsp;
    hawkeye_pkg::din_t     din;
    hawkeye_pkg::dout_t    dout;

    integer             seed = 32'hd994;
    hawkeye_pkg::din_t  rx_exp[$];
    hawkeye_pkg::dout_t tx_exp[$];

    hawkeye_top UUT (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .uart_tx_o    (uart_tx),
        .req_i        (req),
        .gnt_o        (gnt),
        .req_data_i   (req_data),
        .rvalid_o     (rvalid),
        .rready_i     (rready),
        .rsp_o        (rsp),
        .din_i        (din),
        .din_valid_i  (din_valid),
        .din_ready_o  (din_ready),
        .dout_o       (dout),
        .dout_valid_o (dout_valid),
        .dout_ready_i (dout_ready)
    );

    task automatic end_in_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped.");
    endtask

    task automatic value_error(input string msg);
        end_in_failure($sformatf("ERROR at %0d ns: %s", $time, msg));
    endtask

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic hawkeye_pkg::bus_req_t make_req(input logic [3:0] addr, input logic we,
                                                       input logic [3:0] be,
                                                       input logic [31:0] wdata);
        return {addr, we, be, wdata};
    endfunction

    task automatic bus_xfer(input logic [3:0] addr, input logic we, input logic [3:0] be,
                            input logic [31:0] wdata, input int hold,
                            output logic [31:0] rdata);
        @(posedge clk);
        req      <= 1'b1;
        req_data <= make_req(addr, we, be, wdata);
        @(negedge clk);
        while (!gnt) @(negedge clk);
        @(posedge clk);
        req <= 1'b0;
        // The model follows the request at the edge that accepts it.
        if (we && addr == `HAWKEYE_REG_DATA) tx_exp.push_back(wdata);
        if (we && addr == `HAWKEYE_REG_CTRL && wdata[0]) begin
            tx_exp.delete();
            rx_exp.delete();
        end
        @(negedge clk);
        assert (rvalid) else value_error("rvalid_o did not rise one cycle after acceptance");
        rdata = rsp.rdata;
        repeat (hold) begin
            @(negedge clk);
            assert (rvalid && rsp.rdata == rdata)
                else value_error("response changed while rready_i was low");
        end
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic reg_write(input logic [3:0] addr, input logic [3:0] be,
                             input logic [31:0] wdata);
        logic [31:0] rd;
        bus_xfer(addr, 1'b1, be, wdata, rand_below(3), rd);
        assert (rd == '0) else value_error($sformatf("write answered %h, expected 0", rd));
    endtask

    task automatic check_data_read(input int hold);
        logic [31:0] exp;
        logic [31:0] rd;
        exp = '0; // An empty RX FIFO answers zero.
        if (rx_exp.size() != 0) exp = rx_exp.pop_front();
        bus_xfer(`HAWKEYE_REG_DATA, 1'b0, 4'hF, '0, hold, rd);
        assert (rd == exp) else value_error($sformatf("DATA read %h, expected %h", rd, exp));
    endtask

    task automatic check_status(input logic busy);
        hawkeye_pkg::status_t st;
        logic [31:0]          rd;
        bus_xfer(`HAWKEYE_REG_STATUS, 1'b0, 4'hF, '0, rand_below(3), rd);
        st = rd;
        assert (st.rx_level == 8'(rx_exp.size()) && st.tx_level == 8'(tx_exp.size())
                && st.rx_empty == (rx_exp.size() == 0) && st.tx_full == (tx_exp.size() == Depth)
                && st.uart_busy == busy && st.reserved == '0)
            else value_error($sformatf("STATUS read %h, expected rx %0d tx %0d busy %b",
                                       rd, rx_exp.size(), tx_exp.size(), busy));
    endtask

    // Raises a request that must not be granted, then withdraws it.
    task automatic check_stalled(input hawkeye_pkg::bus_req_t rq, input int cycles);
        @(posedge clk);
        req      <= 1'b1;
        req_data <= rq;
        repeat (cycles) begin
            @(negedge clk);
            assert (!gnt) else value_error("request granted while it had to stall");
        end
        @(posedge clk);
        req <= 1'b0;
    endtask

    task automatic din_push(input hawkeye_pkg::din_t word);
        @(posedge clk);
        din       <= word;
        din_valid <= 1'b1;
        @(negedge clk);
        while (!din_ready) @(negedge clk);
        @(posedge clk);
        din_valid <= 1'b0;
        rx_exp.push_back(word);
    endtask

    task automatic random_gap(input int max);
        repeat (rand_below(max + 1)) @(posedge clk);
    endtask

    task automatic dout_random(input logic on);
        @(negedge clk);
        dout_rand_en = on;
    endtask

    task automatic dout_hold(input logic val);
        @(negedge clk);
        dout_rand_en = 1'b0;
        @(posedge clk);
        dout_ready <= val;
    endtask

    // Samples each bit of an 8N1 frame in its middle.
    task automatic check_uart_frame(input logic [7:0] data);
        logic [9:0] frame;
        int         bit_idx;
        frame = {1'b1, data, 1'b0};
        @(negedge clk);
        while (uart_tx) @(negedge clk);
        repeat (Div / 2 - 1) @(negedge clk);
        for (bit_idx = 0; bit_idx < 10; bit_idx++) begin
            if (bit_idx != 0) repeat (Div) @(negedge clk);
            assert (uart_tx == frame[bit_idx])
                else value_error($sformatf("UART bit %0d is %b, expected %b",
                                           bit_idx, uart_tx, frame[bit_idx]));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        logic [31:0] rnd;
        forever begin
            @(posedge clk);
            if (dout_rand_en) begin
                rnd = $random(seed);
                dout_ready <= rnd[0];
            end
        end
    end

    // dout scoreboard.
    initial begin
        hawkeye_pkg::dout_t exp;
        forever begin
            @(negedge clk);
            if (rst_n && dout_valid && dout_ready) begin
                assert (tx_exp.size() != 0) else value_error("dout transfer with no word written");
                exp = tx_exp.pop_front();
                assert (dout == exp) else value_error($sformatf("dout %h, expected %h", dout, exp));
            end
        end
    end

    initial begin
        repeat (WdCycles) @(posedge clk);
        end_in_failure($sformatf("Timeout: the run did not finish within %0d cycles.", WdCycles));
    end

    initial begin
        wait (UUT.i_chk.fail_count != 0);
        end_in_failure("A protocol assertion in hawkeye_chk failed.");
    end

    initial begin
        logic [7:0] byte_a;
        logic [7:0] byte_b;
        int         i;
        req          = 1'b0;
        req_data     = '0;
        rready       = 1'b0;
        din          = '0;
        din_valid    = 1'b0;
        dout_ready   = 1'b0;
        dout_rand_en = 1'b0;
        rst_n        = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        assert (gnt && !rvalid && !dout_valid && din_ready && uart_tx)
            else value_error("outputs not at their reset values");
        check_status(1'b0);

        // Fill the RX FIFO, then din_ready_o must stay low.
        for (i = 0; i < Depth; i++) begin
            random_gap(3);
            din_push($random(seed));
        end
        @(posedge clk);
        din       <= $random(seed);
        din_valid <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            assert (!din_ready) else value_error("din_ready_o high with the RX FIFO full");
        end
        @(posedge clk);
        din_valid <= 1'b0;
        check_status(1'b0);
        for (i = 0; i <= Depth; i++) check_data_read(rand_below(3)); // Last one finds it empty.

        dout_random(1'b1);
        for (i = 0; i < 12; i++) begin
            random_gap(3);
            reg_write(`HAWKEYE_REG_DATA, 4'hF, $random(seed));
        end
        while (tx_exp.size() != 0) @(negedge clk);
        dout_hold(1'b0);
        for (i = 0; i < Depth; i++) reg_write(`HAWKEYE_REG_DATA, 4'hF, $random(seed));
        check_status(1'b0);
        check_stalled(make_req(`HAWKEYE_REG_DATA, 1'b1, 4'hF, $random(seed)), 6);
        dout_hold(1'b1); // One transfer frees one entry.
        dout_hold(1'b0);
        reg_write(`HAWKEYE_REG_DATA, 4'hF, $random(seed));
        check_status(1'b0);
        dout_hold(1'b1);
        while (tx_exp.size() != 0) @(negedge clk);
        @(negedge clk);
        assert (!dout_valid) else value_error("dout_valid_o high with the TX FIFO drained");
        dout_hold(1'b0);

        byte_a = $random(seed);
        byte_b = $random(seed);
        fork
            check_uart_frame(byte_a);
            begin
                reg_write(`HAWKEYE_REG_UART, 4'h1, {24'h0, byte_a});
                check_status(1'b1);
                check_stalled(make_req(`HAWKEYE_REG_UART, 1'b1, 4'h1, {24'h0, byte_b}), 8);
            end
        join
        reg_write(`HAWKEYE_REG_UART, 4'hE, 32'h5A); // Waits for the frame, sends nothing.
        repeat (12 * Div) begin
            @(negedge clk);
            assert (uart_tx) else value_error("frame sent by a UART write without be bit 0");
        end
        fork
            check_uart_frame(byte_b);
            reg_write(`HAWKEYE_REG_UART, 4'h1, {24'h0, byte_b});
        join
        repeat (Div) @(posedge clk);

        for (i = 0; i < 5; i++) reg_write(`HAWKEYE_REG_DATA, 4'hF, $random(seed));
        for (i = 0; i < 3; i++) din_push($random(seed));
        check_data_read(0);
        check_status(1'b0);
        reg_write(`HAWKEYE_REG_CTRL, 4'hF, 32'h1);
        @(negedge clk);
        assert (!dout_valid) else value_error("dout_valid_o high after a flush");
        check_status(1'b0);

        for (i = 0; i < 4; i++) din_push($random(seed));
        for (i = 0; i < 4; i++) check_data_read(1 + rand_below(8));

        repeat (4) @(posedge clk);
        if (UUT.i_chk.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            end_in_failure("A protocol assertion in hawkeye_chk failed.");
        end
    end

endmodule

`default_nettype wire

// ==== hawkeye_top.f ====
+incdir+hw
hw/hawkeye_pkg.sv
hw/hawkeye_stream_fifo.sv
hw/hawkeye_uart_tx.sv
hw/hawkeye_periph.sv
hw/hawkeye_top.sv
verification/hawkeye_chk.sv
verification/hawkeye_tb.sv

// ==== Bender.yml ====
package:
  name: hawkeye

sources:
  - include_dirs:
      - hw
    files:
      - hw/hawkeye_pkg.sv
      - hw/hawkeye_stream_fifo.sv
      - hw/hawkeye_uart_tx.sv
      - hw/hawkeye_periph.sv
      - hw/hawkeye_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/hawkeye_chk.sv
      - verification/hawkeye_tb.sv
